// File: logic/soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

`define DATA_W 32 // width of one bus word
`define ADDR_W 32 // byte address width on every bus

`define RAM_AW 6 // word address bits per bank, so 64 words each

// word offsets of the dma registers inside region 2
`define DMA_REG_SRC 2'd0
`define DMA_REG_DST 2'd1
`define DMA_REG_CNT 2'd2
`define DMA_REG_CTL 2'd3

`endif

// File: logic/bus_pkg.sv
`default_nettype none

`include "soc_cfg.svh"

package bus_pkg;

    // the top two address bits pick one of four regions
    typedef enum logic [1:0] {
        REGION_RAM_A = 2'd0, // data ram bank a
        REGION_RAM_B = 2'd1, // data ram bank b
        REGION_DMA   = 2'd2, // register file of the copy engine
        REGION_NONE  = 2'd3  // unmapped, answered by the decoder itself
    } region_e;

    // one address word seen either flat or split into region and offset
    typedef union packed {
        logic [`ADDR_W-1:0] flat; // plain byte address, used for arithmetic
        struct packed {
            region_e     region; // steers the decoder
            logic [29:0] offset; // byte offset inside the region
        } fields;
    } bus_addr_u;

endpackage

`default_nettype wire

// File: logic/dma_pkg.sv
`default_nettype none

`include "soc_cfg.svh"

package dma_pkg;

    // register index taken from offset bits [3:2] of region 2
    typedef enum logic [1:0] {
        SRC = `DMA_REG_SRC, // source byte address
        DST = `DMA_REG_DST, // destination byte address
        CNT = `DMA_REG_CNT, // number of words still to move
        CTL = `DMA_REG_CTL  // bit 0 starts a copy and reads back as busy
    } dma_reg_e;

    // the copy loop runs read then write for every word
    typedef enum logic [1:0] {
        IDLE  = 2'd0, // waiting for a start from the register side
        READ  = 2'd1, // fetching the word at the source address
        WRITE = 2'd2  // storing the fetched word at the destination
    } dma_state_e;

endpackage

`default_nettype wire

// File: logic/bus_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_cfg.svh"

// one request/response link, a master holds its request until response
interface bus_if
    import bus_pkg::*;
();

    logic               read;       // level, held until response
    logic               write;      // level, held until response
    bus_addr_u          address;    // byte address, both views available
    logic [`DATA_W-1:0] write_data; // valid while write is high
    logic [`DATA_W-1:0] read_data;  // valid together with response
    logic               response;   // single cycle pulse ends the transfer

    // the requesting side
    modport master (
        output read, write, address, write_data,
        input  read_data, response
    );

    // the answering side
    modport slave (
        input  read, write, address, write_data,
        output read_data, response
    );

endinterface

`default_nettype wire

// File: logic/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

// two masters share one bus, ownership is held for a whole transfer
module bus_arbiter (
    input  logic  clk,
    input  logic  rst_n,
    bus_if.slave  host_bus,  // external host port
    bus_if.slave  dma_bus,   // copy engine master port
    bus_if.master shared_bus // toward the decoder
);

    logic owner_valid; // a master currently holds the bus
    logic owner_dma;   // which one, 1 means the dma engine
    logic last_dma;    // the master served most recently
    logic host_req;
    logic dma_req;
    logic grant_dma;   // choice made while the bus is free

    assign host_req = host_bus.read | host_bus.write;
    assign dma_req  = dma_bus.read | dma_bus.write;

    // when both wait the one that was not served last goes first
    assign grant_dma = dma_req & (~host_req | ~last_dma);

    // ============================================================
    // owner register
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner_valid <= 1'b0;
            owner_dma   <= 1'b0;
            last_dma    <= 1'b0;
        end else if (!owner_valid) begin
            if (host_req || dma_req) begin
                owner_valid <= 1'b1; // granted at this edge
                owner_dma   <= grant_dma;
            end
        end else if (shared_bus.response) begin
            // release at the edge after the response, remember who it was
            owner_valid <= 1'b0;
            last_dma    <= owner_dma;
        end
    end

    // ============================================================
    // request path, only the owner reaches the shared bus
    // ============================================================
    assign shared_bus.read  = owner_valid & (owner_dma ? dma_bus.read : host_bus.read);
    assign shared_bus.write = owner_valid & (owner_dma ? dma_bus.write : host_bus.write);
    assign shared_bus.address    = owner_dma ? dma_bus.address : host_bus.address;
    assign shared_bus.write_data = owner_dma ? dma_bus.write_data : host_bus.write_data;

    // the reply goes back to the owner alone, the waiting master sees nothing
    assign host_bus.response  = owner_valid & ~owner_dma & shared_bus.response;
    assign dma_bus.response   = owner_valid & owner_dma & shared_bus.response;
    assign host_bus.read_data = (owner_valid && !owner_dma) ? shared_bus.read_data : '0;
    assign dma_bus.read_data  = (owner_valid && owner_dma) ? shared_bus.read_data : '0;

endmodule

`default_nettype wire

// File: logic/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

// steers each transfer by the top two address bits to one of four regions
module bus_decoder
    import bus_pkg::*;
(
    bus_if.slave  shared_bus, // from the arbiter
    bus_if.master ram_a_bus,  // region 0
    bus_if.master ram_b_bus,  // region 1
    bus_if.master reg_bus     // region 2
);

    region_e region; // region view of the current address
    logic    sel_a;
    logic    sel_b;
    logic    sel_reg;
    logic    sel_none;
    logic    none_response; // region 3 answers within the same cycle

    assign region = shared_bus.address.fields.region;

    assign sel_a    = (region == REGION_RAM_A);
    assign sel_b    = (region == REGION_RAM_B);
    assign sel_reg  = (region == REGION_DMA);
    assign sel_none = (region == REGION_NONE);

    // ============================================================
    // request fan out
    // ============================================================
    // read and write only reach the selected slave
    assign ram_a_bus.read  = shared_bus.read & sel_a;
    assign ram_a_bus.write = shared_bus.write & sel_a;
    assign ram_b_bus.read  = shared_bus.read & sel_b;
    assign ram_b_bus.write = shared_bus.write & sel_b;
    assign reg_bus.read    = shared_bus.read & sel_reg;
    assign reg_bus.write   = shared_bus.write & sel_reg;

    // address and write data are shared by every slave
    assign ram_a_bus.address    = shared_bus.address;
    assign ram_a_bus.write_data = shared_bus.write_data;
    assign ram_b_bus.address    = shared_bus.address;
    assign ram_b_bus.write_data = shared_bus.write_data;
    assign reg_bus.address      = shared_bus.address;
    assign reg_bus.write_data   = shared_bus.write_data;

    // nothing lives in region 3, so any request there ends at once
    assign none_response = sel_none & (shared_bus.read | shared_bus.write);

    // ============================================================
    // reply mux
    // ============================================================
    always_comb begin
        case (region)
            REGION_RAM_A: begin
                shared_bus.read_data = ram_a_bus.read_data;
                shared_bus.response  = ram_a_bus.response;
            end
            REGION_RAM_B: begin
                shared_bus.read_data = ram_b_bus.read_data;
                shared_bus.response  = ram_b_bus.response;
            end
            REGION_DMA: begin
                // response comes from the slave's own pulse, not its data
                shared_bus.read_data = reg_bus.read_data;
                shared_bus.response  = reg_bus.response;
            end
            default: begin
                shared_bus.read_data = '0; // unmapped reads return zero
                shared_bus.response  = none_response;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/word_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_cfg.svh"

// single port word ram, every request is answered one cycle later
module word_ram (
    input  logic clk,
    input  logic rst_n,
    bus_if.slave bus
);

    logic [`DATA_W-1:0] mem [0:(1 << `RAM_AW)-1];
    logic [`RAM_AW-1:0] word_idx; // offset bits above the byte lane
    logic [`DATA_W-1:0] rdata_q;
    logic               req;      // a new request this cycle
    logic               resp_q;

    assign word_idx = bus.address.fields.offset[`RAM_AW+1:2];

    // the request is still visible while the response is high, skip it then
    assign req = (bus.read | bus.write) & ~resp_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_q <= 1'b0;
        end else begin
            resp_q <= req; // one pulse per request
        end
    end

    always_ff @(posedge clk) begin
        if (req && bus.write) begin
            mem[word_idx] <= bus.write_data;
        end
        if (req && bus.read) begin
            rdata_q <= mem[word_idx]; // held until the next read
        end
    end

    assign bus.read_data = rdata_q;
    assign bus.response  = resp_q;

endmodule

`default_nettype wire

// File: logic/dma_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_cfg.svh"

// word copy engine with a register slave on one side and a bus master on the other
module dma_engine
    import bus_pkg::*;
    import dma_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    bus_if.slave  reg_bus, // register access from region 2
    bus_if.master dma_bus, // copy traffic toward the arbiter
    output logic  busy
);

    dma_state_e         state;
    bus_addr_u          src_q;       // next word to read
    bus_addr_u          dst_q;       // next word to write
    logic [`DATA_W-1:0] cnt_q;       // words left to copy
    logic [`DATA_W-1:0] data_q;      // word in flight between read and write
    logic [`DATA_W-1:0] reg_rdata_q;
    logic               reg_resp_q;
    logic               reg_req;     // new register request this cycle
    logic               reg_wr;      // register write that is accepted
    logic               word_done;   // write of one word acknowledged
    dma_reg_e           reg_idx;

    assign reg_idx = dma_reg_e'(reg_bus.address.fields.offset[3:2]);
    assign busy    = (state != IDLE);

    // ============================================================
    // register slave
    // ============================================================
    assign reg_req   = (reg_bus.read | reg_bus.write) & ~reg_resp_q;
    assign reg_wr    = reg_req & reg_bus.write & ~busy; // writes while busy are dropped
    assign word_done = (state == WRITE) & dma_bus.response;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_resp_q <= 1'b0;
        end else begin
            reg_resp_q <= reg_req; // answered even when the write is dropped
        end
    end

    always_ff @(posedge clk) begin
        if (reg_req && reg_bus.read) begin
            case (reg_idx)
                SRC:     reg_rdata_q <= src_q.flat;
                DST:     reg_rdata_q <= dst_q.flat;
                CNT:     reg_rdata_q <= cnt_q;
                default: reg_rdata_q <= {{(`DATA_W-1){1'b0}}, busy}; // CTL shows busy in bit 0
            endcase
        end
    end

    assign reg_bus.read_data = reg_rdata_q;
    assign reg_bus.response  = reg_resp_q;

    // ============================================================
    // copy state machine
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt_q <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (reg_wr && reg_idx == CNT) begin
                        cnt_q <= reg_bus.write_data;
                    end
                    // a zero count never starts the loop
                    if (reg_wr && reg_idx == CTL && reg_bus.write_data[0] && cnt_q != '0) begin
                        state <= READ;
                    end
                end
                READ: begin
                    if (dma_bus.response) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    if (word_done) begin
                        cnt_q <= cnt_q - `DATA_W'd1;
                        state <= (cnt_q == `DATA_W'd1) ? IDLE : READ; // last word ends busy
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // address counters and the word carried from the read to the write
    always_ff @(posedge clk) begin
        if (reg_wr && reg_idx == SRC) begin
            src_q.flat <= reg_bus.write_data;
        end else if (word_done) begin
            src_q.flat <= src_q.flat + `ADDR_W'd4;
        end
        if (reg_wr && reg_idx == DST) begin
            dst_q.flat <= reg_bus.write_data;
        end else if (word_done) begin
            dst_q.flat <= dst_q.flat + `ADDR_W'd4;
        end
        if (state == READ && dma_bus.response) begin
            data_q <= dma_bus.read_data; // captured with the read pulse
        end
    end

    assign dma_bus.read       = (state == READ);
    assign dma_bus.write      = (state == WRITE);
    assign dma_bus.address    = (state == WRITE) ? dst_q : src_q;
    assign dma_bus.write_data = data_q;

endmodule

`default_nettype wire

// File: logic/soc_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_cfg.svh"

// host port, copy engine, arbiter, decoder and two ram banks
module soc_bus_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               host_read,
    input  logic               host_write,
    input  logic [`ADDR_W-1:0] host_address,
    input  logic [`DATA_W-1:0] host_write_data,
    output logic [`DATA_W-1:0] host_read_data,
    output logic               host_response,
    output logic               dma_busy
);

    bus_if host_bus ();   // host side of the arbiter
    bus_if dma_bus ();    // copy engine side of the arbiter
    bus_if shared_bus (); // arbiter to decoder
    bus_if ram_a_bus ();  // region 0
    bus_if ram_b_bus ();  // region 1
    bus_if reg_bus ();    // region 2

    // ============================================================
    // host port onto its bus
    // ============================================================
    assign host_bus.read       = host_read;
    assign host_bus.write      = host_write;
    assign host_bus.address    = host_address; // flat view of the union
    assign host_bus.write_data = host_write_data;
    assign host_read_data      = host_bus.read_data;
    assign host_response       = host_bus.response;

    bus_arbiter bus_arbiter_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_bus   (host_bus),
        .dma_bus    (dma_bus),
        .shared_bus (shared_bus)
    );

    bus_decoder bus_decoder_inst (
        .shared_bus (shared_bus),
        .ram_a_bus  (ram_a_bus),
        .ram_b_bus  (ram_b_bus),
        .reg_bus    (reg_bus)
    );

    word_ram ram_a_inst (.clk(clk), .rst_n(rst_n), .bus(ram_a_bus));
    word_ram ram_b_inst (.clk(clk), .rst_n(rst_n), .bus(ram_b_bus));

    dma_engine dma_engine_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .reg_bus (reg_bus),
        .dma_bus (dma_bus),
        .busy    (dma_busy)
    );

endmodule

`default_nettype wire

// File: bench/soc_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_cfg.svh"

module soc_bus_tb;

    localparam logic [31:0] bank_a_base = 32'h0000_0000; // region 0
    localparam logic [31:0] bank_b_base = 32'h4000_0000; // region 1
    localparam logic [31:0] dma_base    = 32'h8000_0000; // region 2
    localparam logic [31:0] none_base   = 32'hc000_0000; // region 3, nothing mapped
    localparam int response_limit = 50;   // cycles a single transfer may take
    localparam int busy_limit     = 4000; // cycles a whole copy may take

    logic               clk = 1'b0;
    logic               rst_n;
    logic               host_read;
    logic               host_write;
    logic [`ADDR_W-1:0] host_address;
    logic [`DATA_W-1:0] host_write_data;
    logic [`DATA_W-1:0] host_read_data;
    logic               host_response;
    logic               dma_busy;

    // shadow copies of both banks and of the dma registers
    logic [`DATA_W-1:0] shadow_a [0:(1 << `RAM_AW)-1];
    logic [`DATA_W-1:0] shadow_b [0:(1 << `RAM_AW)-1];
    logic [`DATA_W-1:0] shadow_src;
    logic [`DATA_W-1:0] shadow_dst;
    logic [`DATA_W-1:0] shadow_cnt;

    logic [31:0]        rng_state = 32'd73827;
    logic [`DATA_W-1:0] exp_data;     // reference value for the read in flight
    logic [`ADDR_W-1:0] exp_addr;
    logic               read_pending; // a host read waits for its response
    int read_checks   = 0;
    int read_errors   = 0;
    int other_errors  = 0; // timeouts and missing busy edges
    int errors_before = 0;
    int tests_done    = 0;

    soc_bus_top soc_bus_top_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .host_read       (host_read),
        .host_write      (host_write),
        .host_address    (host_address),
        .host_write_data (host_write_data),
        .host_read_data  (host_read_data),
        .host_response   (host_response),
        .dma_busy        (dma_busy)
    );

    always #10 clk = ~clk; // 20 ns period

    // ============================================================
    // reference model
    // ============================================================
    // 32 bit xorshift, the sequence is fixed by the seed
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // what a host read of addr must return, following the region map
    function automatic logic [`DATA_W-1:0] expected_read(input logic [`ADDR_W-1:0] addr);
        case (addr[31:30])
            2'd0: return shadow_a[addr[`RAM_AW+1:2]]; // word index sits above the byte lane
            2'd1: return shadow_b[addr[`RAM_AW+1:2]];
            2'd2: begin
                case (addr[3:2])
                    `DMA_REG_SRC: return shadow_src;
                    `DMA_REG_DST: return shadow_dst;
                    `DMA_REG_CNT: return shadow_cnt;
                    default:      return '0; // ctl shows busy, reads of it only happen idle
                endcase
            end
            default: return '0; // unmapped space always reads zero
        endcase
    endfunction

    // keeps the shadows in step with a completed write
    task automatic record_write(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
        case (addr[31:30])
            2'd0: shadow_a[addr[`RAM_AW+1:2]] = data;
            2'd1: shadow_b[addr[`RAM_AW+1:2]] = data;
            2'd2: begin
                if (addr[3:2] == `DMA_REG_SRC) shadow_src = data;
                if (addr[3:2] == `DMA_REG_DST) shadow_dst = data;
                if (addr[3:2] == `DMA_REG_CNT) shadow_cnt = data;
            end
            default: ; // a write to region 3 changes nothing
        endcase
    endtask

    function automatic logic [`ADDR_W-1:0] reg_addr(input logic [1:0] idx);
        return {dma_base[31:4], idx, 2'b00};
    endfunction

    // ============================================================
    // host port driver
    // ============================================================
    task automatic host_access(input logic is_write, input logic [`ADDR_W-1:0] addr,
                               input logic [`DATA_W-1:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        exp_data        = expected_read(addr); // reference taken before the transfer starts
        exp_addr        = addr;
        read_pending    = !is_write;
        host_address    = addr;
        host_write_data = data;
        host_read       = !is_write;
        host_write      = is_write;
        do begin
            @(posedge clk);
            waited++;
        end while (!host_response && waited < response_limit);
        if (!host_response) begin
            other_errors++;
            $display("host %s at address %h got no response within %0d cycles",
                     is_write ? "write" : "read", addr, response_limit);
        end else if (is_write) begin
            record_write(addr, data);
        end
        @(negedge clk); // the request drops in the cycle after the response
        host_read    = 1'b0;
        host_write   = 1'b0;
        read_pending = 1'b0;
    endtask

    task automatic wait_busy(input logic level);
        int waited;
        waited = 0;
        while (dma_busy !== level && waited < busy_limit) begin
            @(negedge clk); // busy is registered, so the falling edge sees it settled
            waited++;
        end
        if (dma_busy !== level) begin
            other_errors++;
            $display("dma_busy did not go %s within %0d cycles", level ? "high" : "low", busy_limit);
        end
    endtask

    // programs a copy, reads bank a while it runs, then checks the whole destination
    task automatic run_copy(input logic [`ADDR_W-1:0] src, input logic [`ADDR_W-1:0] dst,
                            input int count, input int reads);
        int i;
        host_access(1'b1, reg_addr(`DMA_REG_SRC), src);
        host_access(1'b1, reg_addr(`DMA_REG_DST), dst);
        host_access(1'b1, reg_addr(`DMA_REG_CNT), 32'(count));
        host_access(1'b1, reg_addr(`DMA_REG_CTL), 32'h1); // bit 0 starts the loop
        wait_busy(1'b1);
        for (i = 0; i < reads; i++) begin
            host_access(1'b0, bank_a_base + ((next_random() % 64) << 2), 32'h0);
        end
        wait_busy(1'b0);
        for (i = 0; i < count; i++) begin
            record_write(dst + 32'(i * 4), expected_read(src + 32'(i * 4))); // word by word
        end
        // both addresses end one word past the copy and the count runs down to zero
        record_write(reg_addr(`DMA_REG_SRC), src + 32'(count * 4));
        record_write(reg_addr(`DMA_REG_DST), dst + 32'(count * 4));
        record_write(reg_addr(`DMA_REG_CNT), 32'h0);
        for (i = 0; i < count; i++) begin
            host_access(1'b0, dst + 32'(i * 4), 32'h0);
        end
        host_access(1'b0, reg_addr(`DMA_REG_SRC), 32'h0);
        host_access(1'b0, reg_addr(`DMA_REG_DST), 32'h0);
        host_access(1'b0, reg_addr(`DMA_REG_CNT), 32'h0);
    endtask

    task automatic report_test(input string name);
        int errs;
        errs = read_errors + other_errors - errors_before;
        tests_done++;
        if (errs == 0) begin
            $display("test %0d %s: ok", tests_done, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_done, name, errs);
        end
        errors_before = read_errors + other_errors;
    endtask

    // compare process, every host read is checked at its response edge
    always @(posedge clk) begin
        if (rst_n && host_response && read_pending) begin
            read_checks++;
            if (host_read_data !== exp_data) begin
                read_errors++;
                $display("FAILED host_read_data at address %h: got %h, expected %h",
                         exp_addr, host_read_data, exp_data);
            end
        end
    end

    // ============================================================
    // test sequence
    // ============================================================
    initial begin
        int i;
        logic [`ADDR_W-1:0] off;
        logic [`DATA_W-1:0] count;
        rst_n           = 1'b0;
        host_read       = 1'b0;
        host_write      = 1'b0;
        host_address    = '0;
        host_write_data = '0;
        read_pending    = 1'b0;
        exp_data        = '0;
        exp_addr        = '0;
        repeat (2) @(negedge clk); // two full cycles of reset
        rst_n = 1'b1;

        for (i = 0; i < 64; i++) begin
            host_access(1'b1, bank_a_base + 32'(i * 4), next_random());
        end
        for (i = 0; i < 64; i++) begin
            host_access(1'b0, bank_a_base + 32'(i * 4), 32'h0);
        end
        report_test("bank a write and read");

        for (i = 0; i < 64; i++) begin
            host_access(1'b1, bank_b_base + 32'(i * 4), next_random()); // fills all of b
        end
        for (i = 0; i < 8; i++) begin
            off = (next_random() % 64) << 2;
            host_access(1'b0, bank_a_base + off, 32'h0);
            host_access(1'b0, bank_b_base + off, 32'h0);
        end
        report_test("banks independent");

        for (i = 0; i < 8; i++) begin
            off = (next_random() % 64) << 2;
            host_access(1'b1, none_base + off, next_random());
            host_access(1'b0, none_base + off, 32'h0);
            host_access(1'b0, bank_a_base + off, 32'h0); // must be untouched
            host_access(1'b0, bank_b_base + off, 32'h0);
        end
        report_test("unmapped region");

        host_access(1'b1, reg_addr(`DMA_REG_SRC), bank_a_base + ((next_random() % 64) << 2));
        host_access(1'b1, reg_addr(`DMA_REG_DST), bank_b_base + ((next_random() % 64) << 2));
        host_access(1'b1, reg_addr(`DMA_REG_CNT), 1 + next_random() % 64);
        host_access(1'b0, reg_addr(`DMA_REG_SRC), 32'h0);
        host_access(1'b0, reg_addr(`DMA_REG_DST), 32'h0);
        host_access(1'b0, reg_addr(`DMA_REG_CNT), 32'h0);
        host_access(1'b0, reg_addr(`DMA_REG_CTL), 32'h0);
        report_test("dma register readback");

        count = 1 + next_random() % 32;
        run_copy(bank_a_base + ((next_random() % 32) << 2),
                 bank_b_base + ((next_random() % 32) << 2), int'(count), 0);
        report_test("dma copy a to b");

        count = 24 + next_random() % 16; // long enough for host reads to overlap
        run_copy(bank_a_base + ((next_random() % 16) << 2),
                 bank_b_base + ((next_random() % 16) << 2), int'(count), 8);
        report_test("host reads during copy");

        $display("tests %0d, read checks %0d, errors %0d",
                 tests_done, read_checks, read_errors + other_errors);
        if (read_errors + other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+logic
logic/bus_pkg.sv
logic/dma_pkg.sv
logic/bus_if.sv
logic/bus_arbiter.sv
logic/bus_decoder.sv
logic/word_ram.sv
logic/dma_engine.sv
logic/soc_bus_top.sv
bench/soc_bus_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line in the log
verilator --binary --timescale 1ns/1ps --top-module soc_bus_tb -f compile.f \
    -o soc_bus_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/soc_bus_sim > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -qx '\*\* PASS \*\*' sim.log && echo "result: pass" \
    || { echo "result: fail"; exit 1; }
